// ==== Makefile ====
SIM = obj_dir/memUnitSim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f sim.f --top-module memUnitTb -o memUnitSim

run: compile
	./$(SIM) | tee run.log
	grep -qF "*** TEST PASSED ***" run.log

clean:
	rm -rf obj_dir run.log

// ==== bench/memUnitTb.sv ====
`timescale 1ns/10ps
`include "memUnit_defines.svh"

// directed testbench for the memory slice
module memUnitTb
	import memUnitPkg::*;
;

	logic                clk;
	logic                arstN;
	logic                issue;
	logic [`INST_W-1:0]  inst;
	logic [`WORD_W-1:0]  a;
	logic [`WORD_W-1:0]  b;
	logic [`WORD_W-1:0]  c;
	logic                idle;
	logic                done;
	logic                fault;
	logic [`WORD_W-1:0]  result;

	// shadow copy of the data memory where only written addresses are compared
	logic [`WORD_W-1:0] shadow [0:255];
	logic [31:0]        rngState;
	int                 errCount;
	int                 timeoutCount;

	memUnitTop dut_i (
		.clk    (clk),
		.arstN  (arstN),
		.issue  (issue),
		.inst   (inst),
		.a      (a),
		.b      (b),
		.c      (c),
		.idle   (idle),
		.done   (done),
		.fault  (fault),
		.result (result)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ==============================
	// random data and instruction words
	// ==============================

	function automatic logic [31:0] xorshift();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	// three draws give a full 80 bit word
	function automatic logic [`WORD_W-1:0] randWord();
		logic [31:0] r0;
		logic [31:0] r1;
		logic [31:0] r2;
		r0 = xorshift();
		r1 = xorshift();
		r2 = xorshift();
		return {r2[15:0], r1, r0};
	endfunction

	// opcode high bits go to 34:33 and low bits to 9:6
	function automatic logic [`INST_W-1:0] opWord(input logic [5:0] mop);
		logic [`INST_W-1:0] w;
		w = '0;
		w[34:33] = mop[5:4];
		w[9:6] = mop[3:0];
		return w;
	endfunction

	function automatic logic [`INST_W-1:0] loadInst(input logic [19:0] d);
		logic [`INST_W-1:0] w;
		w = opWord(6'h02);
		w[39:35] = d[19:15];
		w[30:16] = d[14:0];
		return w;
	endfunction

	function automatic logic [`INST_W-1:0] storeInst(input logic [19:0] d);
		logic [`INST_W-1:0] w;
		w = opWord(6'h13);
		w[39:35] = d[19:15];
		w[30:22] = d[14:6];
		w[5:0] = d[5:0];
		return w;
	endfunction

	// indexed forms carry the scale in 30:28 and a six bit offset
	function automatic logic [`INST_W-1:0] indexInst(input logic isStore, input logic [2:0] sc,
		input logic [5:0] ofs);
		logic [`INST_W-1:0] w;
		w = opWord(isStore ? 6'h1F : 6'h0E);
		w[30:28] = sc;
		if (isStore) begin
			w[5:0] = ofs;
		end else begin
			w[21:16] = ofs;
		end
		return w;
	endfunction

	// ==============================
	// reference model
	// ==============================

	function automatic memOp_t classify(input logic [`INST_W-1:0] w);
		logic [5:0] mop;
		mop = {w[34:33], w[9:6]};
		if (mop == 6'h0F) return opAmo;
		if (mop == 6'h1D || mop == 6'h1E) return opPush;
		if (mop[5:4] == 2'b00) return opLoad;
		if (mop[5:4] == 2'b01) return opStore;
		return opIllegal;
	endfunction

	function automatic logic [`WORD_W-1:0] refAddr(input logic [`INST_W-1:0] w,
		input logic [`WORD_W-1:0] aV, input logic [`WORD_W-1:0] cV);
		logic [5:0]         mop;
		logic [19:0]        dl;
		logic [19:0]        ds;
		logic [`WORD_W-1:0] mult;
		mop = {w[34:33], w[9:6]};
		dl = {w[39:35], w[30:16]};
		ds = {w[39:35], w[30:22], w[5:0]};
		case (w[30:28])
			3'd0: mult = 1;
			3'd1: mult = 2;
			3'd2: mult = 4;
			3'd3: mult = 8;
			3'd4: mult = 16;
			3'd5: mult = 5;
			3'd6: mult = 10;
			default: mult = 15;
		endcase
		if (mop == 6'h0F) return aV;
		if (mop == 6'h0E) return aV + cV * mult + {74'd0, w[21:16]};
		if (mop == 6'h1F) return aV + cV * mult + {74'd0, w[5:0]};
		if (mop == 6'h1D) return aV - {75'd0, w[27:23]};
		if (mop == 6'h1E) return aV - 80'd10;
		if (mop[5:4] == 2'b01) return aV + {{60{ds[19]}}, ds};
		return aV + {{60{dl[19]}}, dl};
	endfunction

	// ==============================
	// handshake helpers
	// ==============================

	task automatic waitIdle();
		int n;
		n = 0;
		@(negedge clk);
		while (!idle && n < 100) begin
			@(negedge clk);
			n++;
		end
		if (!idle) begin
			$display("Error at %0t: unit never returned to idle", $time);
			timeoutCount++;
		end
	endtask

	// issues one instruction and checks latency, fault and result against the model
	task automatic runOp(input logic [`INST_W-1:0] w, input logic [`WORD_W-1:0] aV,
		input logic [`WORD_W-1:0] bV, input logic [`WORD_W-1:0] cV);
		memOp_t             op;
		logic [`WORD_W-1:0] addr;
		logic [`WORD_W-1:0] expRes;
		logic               expFault;
		int                 expCycles;
		int                 cycles;
		logic               seen;
		op = classify(w);
		addr = refAddr(w, aV, cV);
		expFault = (op == opIllegal) || (addr >= 256);
		expCycles = expFault ? 2 : ((op == opAmo) ? 4 : 3);
		case (op)
			opLoad: expRes = shadow[addr[7:0]];
			opAmo: expRes = shadow[addr[7:0]];
			opPush: expRes = addr;
			default: expRes = '0;
		endcase
		waitIdle();
		@(posedge clk);
		issue <= 1'b1;
		inst <= w;
		a <= aV;
		b <= bV;
		c <= cV;
		@(posedge clk);
		issue <= 1'b0;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < 20) begin
			@(negedge clk);
			cycles++;
			if (done) begin
				seen = 1'b1;
			end else begin
				@(posedge clk);
			end
		end
		if (!seen) begin
			$display("Error at %0t: done never came for instruction %h", $time, w);
			timeoutCount++;
			return;
		end
		if (cycles != expCycles) begin
			$display("Mismatch at %0t: done after %0d cycles, expected %0d", $time, cycles,
				expCycles);
			errCount++;
		end
		if (fault !== expFault) begin
			$display("Mismatch at %0t: fault %b, expected %b", $time, fault, expFault);
			errCount++;
		end
		if (!expFault && result !== expRes) begin
			$display("Mismatch at %0t: result %h, expected %h", $time, result, expRes);
			errCount++;
		end
		if (!expFault) begin
			if (op == opStore || op == opPush) shadow[addr[7:0]] = bV;
			if (op == opAmo) shadow[addr[7:0]] = expRes + bV;
		end
	endtask

	// ==============================
	// directed tests
	// ==============================

	task automatic testDisp();
		int sd [4];
		int lb [4];
		int tgt;
		sd = '{5, -7, 20, -30};
		lb = '{60, 130, 60, 130};
		for (int i = 0; i < 4; i++) begin
			runOp(storeInst(20'(sd[i])), 80'd100, randWord(), '0);
		end
		// read back through the load form from other bases
		for (int i = 0; i < 4; i++) begin
			tgt = 100 + sd[i];
			runOp(loadInst(20'(tgt - lb[i])), 80'(lb[i]), '0, '0);
		end
	endtask

	task automatic testScale();
		logic [`WORD_W-1:0] addr;
		for (int s = 0; s < 8; s++) begin
			runOp(indexInst(1'b1, 3'(s), 6'(s + 1)), 80'd10, randWord(), 80'd3);
			runOp(indexInst(1'b0, 3'(s), 6'(s + 1)), 80'd10, '0, 80'd3);
			// a plain load at the model address sees the same word
			addr = refAddr(indexInst(1'b1, 3'(s), 6'(s + 1)), 80'd10, 80'd3);
			runOp(loadInst(20'd0), addr, '0, '0);
		end
	endtask

	task automatic testPush();
		logic [4:0]         f5 [4];
		logic [`INST_W-1:0] w;
		f5 = '{5'd0, 5'd3, 5'd17, 5'd31};
		for (int i = 0; i < 4; i++) begin
			w = opWord(6'h1D);
			w[27:23] = f5[i];
			runOp(w, 80'd200, randWord(), '0);
			runOp(loadInst(20'd0), 80'd200 - 80'(f5[i]), '0, '0);
		end
		runOp(opWord(6'h1E), 80'd200, randWord(), '0);
		runOp(loadInst(20'd0), 80'd190, '0, '0);
	endtask

	task automatic testAmo();
		for (int i = 0; i < 3; i++) begin
			runOp(storeInst(20'd0), 80'd40 + 80'(i), randWord(), '0);
			runOp(opWord(6'h0F), 80'd40 + 80'(i), randWord(), '0);
			runOp(loadInst(20'd0), 80'd40 + 80'(i), '0, '0);
		end
	endtask

	task automatic testFault();
		runOp(storeInst(20'd0), 80'd30, randWord(), '0);
		runOp(storeInst(20'd0), 80'd4, randWord(), '0);
		// 260 would land on word 4 if its upper bits were dropped
		runOp(storeInst(20'd10), 80'd250, randWord(), '0);
		runOp(loadInst(20'd0), 80'd4, '0, '0);
		runOp(loadInst(20'd6), 80'd250, '0, '0);
		// class 2'b10 is not a memory class
		runOp(opWord(6'h20), 80'd30, randWord(), '0);
		runOp(loadInst(20'd0), 80'd30, '0, '0);
	endtask

	task automatic testBusy();
		logic [`WORD_W-1:0] first;
		int                 doneCount;
		runOp(storeInst(20'd0), 80'd80, randWord(), '0);
		runOp(storeInst(20'd0), 80'd81, randWord(), '0);
		first = randWord();
		waitIdle();
		@(posedge clk);
		issue <= 1'b1;
		inst <= storeInst(20'd0);
		a <= 80'd80;
		b <= first;
		@(posedge clk);
		// second store to 81 arrives while the first is in flight
		a <= 80'd81;
		b <= randWord();
		@(posedge clk);
		issue <= 1'b0;
		doneCount = 0;
		for (int i = 0; i < 12; i++) begin
			@(negedge clk);
			if (done) doneCount++;
		end
		if (doneCount != 1) begin
			$display("Mismatch at %0t: %0d done pulses, expected 1", $time, doneCount);
			errCount++;
		end
		shadow[80] = first;
		runOp(loadInst(20'd0), 80'd80, '0, '0);
		runOp(loadInst(20'd0), 80'd81, '0, '0);
	endtask

	initial begin
		rngState = 32'h1bcc;
		errCount = 0;
		timeoutCount = 0;
		arstN = 1'b0;
		issue = 1'b0;
		inst = '0;
		a = '0;
		b = '0;
		c = '0;
		repeat (10) @(posedge clk);
		arstN <= 1'b1;
		@(negedge clk);
		if (idle !== 1'b1 || done !== 1'b0 || fault !== 1'b0 || result !== '0) begin
			$display("Mismatch at %0t: after reset idle %b done %b fault %b result %h", $time,
				idle, done, fault, result);
			errCount++;
		end
		testDisp();
		testScale();
		testPush();
		testAmo();
		testFault();
		testBusy();
		$display("errors: %0d mismatches, %0d timeouts", errCount, timeoutCount);
		if (errCount == 0 && timeoutCount == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== hw/agen.sv ====
`timescale 1ns/10ps
`include "memUnit_defines.svh"

// address generator for memory instructions
// purely combinational so the address is ready in the same cycle
module agen
	import memUnitPkg::*;
(
	input  memInst_t            inst,
	input  logic [`WORD_W-1:0]  a,
	input  logic [`WORD_W-1:0]  c,
	output logic [`WORD_W-1:0]  ma
);

	// opcode rebuilt from its two fields
	logic [5:0]         mop;
	// scale code and the scaled index
	logic [2:0]         scale;
	logic [`WORD_W-1:0] cx;
	// sign extended displacements of the two instruction forms
	logic [`WORD_W-1:0] ldDisp;
	logic [`WORD_W-1:0] stDisp;
	// small zero extended offsets of the indexed forms
	logic [`WORD_W-1:0] mlxOfs;
	logic [`WORD_W-1:0] msxOfs;
	// stack decrement of a plain push
	logic [`WORD_W-1:0] pushDec;

	assign mop   = {inst[`OPC_HI], inst[`OPC_LO]};
	assign scale = inst[`SCALE_LO +: 3];

	// ==============================
	// index scaling
	// ==============================

	// powers of two are plain shifts
	// 5, 10 and 15 come from one add or subtract of two shifts
	always_comb begin
		case (scale)
			3'd0: cx = c;
			3'd1: cx = c << 1;
			3'd2: cx = c << 2;
			3'd3: cx = c << 3;
			3'd4: cx = c << 4;
			3'd5: cx = (c << 2) + c;
			3'd6: cx = (c << 3) + (c << 1);
			default: cx = (c << 4) - c;
		endcase
	end

	// ==============================
	// displacement forms
	// ==============================

	// load form is dispHi above the 15 bit low field, 20 bits in all
	assign ldDisp = {{(`WORD_W-20){inst.ld.dispHi[4]}}, inst.ld.dispHi, inst.ld.dispLo};

	// store form gathers three pieces into the same 20 bits
	assign stDisp = {{(`WORD_W-20){inst.st.dispHi[4]}}, inst.st.dispHi,
		inst.st.dispMid, inst.st.dispLo};

	// indexed load takes bits 21:16, the bottom of the load displacement
	assign mlxOfs = {{(`WORD_W-6){1'b0}}, inst.ld.dispLo[5:0]};
	// indexed store takes bits 5:0
	assign msxOfs = {{(`WORD_W-6){1'b0}}, inst.st.dispLo};

	// the push decrement is an unsigned five bit field
	assign pushDec  = {{(`WORD_W-5){1'b0}}, inst[`FUNCT5]};

	// ==============================
	// address select
	// ==============================

	// the class is picked first and the exact opcode inside it
	always_comb begin
		casez (mop)
			`LOAD: begin
				case (mop)
					// atomics address memory through the base alone
					`AMO: ma = a;
					`MLX: ma = a + cx + mlxOfs;
					default: ma = a + ldDisp;
				endcase
			end
			`STORE: begin
				case (mop)
					`PUSH: ma = a - pushDec;
					`PUSHC: ma = a - `WORD_W'(`PUSHC_DEC);
					`MSX: ma = a + cx + msxOfs;
					default: ma = a + stDisp;
				endcase
			end
			// illegal classes still produce an address and the control faults them
			default: ma = a + ldDisp;
		endcase
	end

endmodule

// ==== hw/dataMem.sv ====
`timescale 1ns/10ps
`include "memUnit_defines.svh"

// single port word memory
// one access per cycle, reads come out one cycle after re
module dataMem (
	input  logic                clk,
	input  logic                arstN,
	input  logic                we,
	input  logic                re,
	input  logic [`MEM_AW-1:0]  addr,
	input  logic [`WORD_W-1:0]  wdata,
	output logic [`WORD_W-1:0]  rdata
);

	// 256 words of 80 bits
	logic [`WORD_W-1:0] mem [0:(1 << `MEM_AW) - 1];

	// write on the clock edge while we is high
	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
	end

	// read port register holds its word until the next read
	// a write to the same address in the same cycle returns the old word
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			rdata <= '0;
		end else if (re) begin
			rdata <= mem[addr];
		end
	end

endmodule

// ==== hw/memCtrl.sv ====
`timescale 1ns/10ps
`include "memUnit_defines.svh"

// sequencer for one memory instruction at a time
// it captures the operands, checks the address and drives the data memory
module memCtrl
	import memUnitPkg::*;
(
	input  logic                clk,
	input  logic                arstN,
	input  logic                issue,
	input  logic [`INST_W-1:0]  inst,
	input  logic [`WORD_W-1:0]  a,
	input  logic [`WORD_W-1:0]  b,
	input  logic [`WORD_W-1:0]  c,
	input  logic [`WORD_W-1:0]  ma,
	input  logic [`WORD_W-1:0]  memRdata,
	output memInst_t            instQ,
	output logic [`WORD_W-1:0]  aQ,
	output logic [`WORD_W-1:0]  cQ,
	output logic [`MEM_AW-1:0]  memAddr,
	output logic                memWe,
	output logic                memRe,
	output logic [`WORD_W-1:0]  memWdata,
	output logic                idle,
	output logic                done,
	output logic                fault,
	output logic [`WORD_W-1:0]  result
);

	ctrlState_t         state;
	ctrlState_t         stateNext;
	// operation class of the instruction in flight
	memOp_t             op;
	memOp_t             opIn;
	logic [5:0]         mopIn;
	// store data and the registered address
	logic [`WORD_W-1:0] bQ;
	logic [`WORD_W-1:0] maQ;
	// word read by an atomic, kept for the add and the result
	logic [`WORD_W-1:0] oldQ;
	logic               inRange;
	logic               isRead;

	// ==============================
	// decode
	// ==============================

	assign mopIn = {inst[`OPC_HI], inst[`OPC_LO]};

	// the first match wins, so the exact opcodes sit above their class
	always_comb begin
		casez (mopIn)
			`AMO: opIn = opAmo;
			`PUSH, `PUSHC: opIn = opPush;
			`LOAD: opIn = opLoad;
			`STORE: opIn = opStore;
			default: opIn = opIllegal;
		endcase
	end

	// loads and atomics both start with a read
	assign isRead = (op == opLoad) || (op == opAmo);

	// every bit above the memory index must be zero
	assign inRange = ~|ma[`WORD_W-1:`MEM_AW];

	// ==============================
	// state machine
	// ==============================

	always_comb begin
		stateNext = state;
		case (state)
			stIdle: begin
				if (issue) begin
					stateNext = stAddr;
				end
			end
			stAddr: begin
				if (op == opIllegal || !inRange) begin
					stateNext = stFault;
				end else if (isRead) begin
					stateNext = stRead;
				end else begin
					stateNext = stWrite;
				end
			end
			// an atomic goes on to write back the sum
			stRead: stateNext = (op == opAmo) ? stWrite : stDone;
			stWrite: stateNext = stDone;
			// done and fault last one cycle each
			default: stateNext = stIdle;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= stIdle;
			op    <= opIllegal;
		end else begin
			state <= stateNext;
			// issue while busy is dropped here since the state is not idle
			if (state == stIdle && issue) begin
				op <= opIn;
			end
		end
	end

	// ==============================
	// operands and addresses
	// ==============================

	always_ff @(posedge clk) begin
		if (state == stIdle && issue) begin
			instQ <= inst;
			aQ    <= a;
			bQ    <= b;
			cQ    <= c;
		end
		// address is frozen once agen has settled on the captured operands
		if (state == stAddr) begin
			maQ <= ma;
		end
		if (state == stRead) begin
			oldQ <= memRdata;
		end
	end

	// ==============================
	// memory port
	// ==============================

	// reads are launched straight from agen during stAddr
	// so that the word arrives while the sequencer is in stRead
	assign memRe    = (state == stAddr) && isRead && inRange;
	assign memAddr  = (state == stAddr) ? ma[`MEM_AW-1:0] : maQ[`MEM_AW-1:0];
	assign memWe    = (state == stWrite);
	// atomic sum wraps at 80 bits
	assign memWdata = (op == opAmo) ? oldQ + bQ : bQ;

	// ==============================
	// status and result
	// ==============================

	assign idle  = (state == stIdle);
	assign done  = (state == stDone) || (state == stFault);
	assign fault = (state == stFault);

	// result only changes on the edge that enters stDone or stFault
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			result <= '0;
		end else begin
			case (state)
				stAddr: begin
					if (stateNext == stFault) begin
						result <= '0;
					end
				end
				stRead: begin
					if (op == opLoad) begin
						result <= memRdata;
					end
				end
				stWrite: begin
					case (op)
						opAmo: result <= oldQ;
						// new stack pointer goes back to the core
						opPush: result <= maQ;
						default: result <= '0;
					endcase
				end
				default: result <= result;
			endcase
		end
	end

endmodule

// ==== hw/memUnitPkg.sv ====
package memUnitPkg;

	// ==============================
	// instruction views
	// ==============================

	// load form keeps a 15 bit low displacement in bits 30 to 16
	typedef struct packed {
		logic [4:0]  dispHi;
		logic [1:0]  opHi;
		logic [1:0]  rsvd;
		logic [14:0] dispLo;
		logic [5:0]  srcHi;
		logic [3:0]  opLo;
		logic [5:0]  srcLo;
	} memLdView_t;

	// store form splits its displacement around the register fields
	// so the low six bits sit in the bottom of the word
	typedef struct packed {
		logic [4:0]  dispHi;
		logic [1:0]  opHi;
		logic [1:0]  rsvd;
		logic [8:0]  dispMid;
		logic [11:0] srcMid;
		logic [3:0]  opLo;
		logic [5:0]  dispLo;
	} memStView_t;

	// one 40 bit instruction word read either way
	typedef union packed {
		memLdView_t ld;
		memStView_t st;
	} memInst_t;

	// ==============================
	// operation and control state
	// ==============================

	// class of the operation picked at issue time
	typedef enum logic [2:0] {opLoad, opStore, opPush, opAmo, opIllegal} memOp_t;

	// states of the memory sequencer
	typedef enum logic [2:0] {stIdle, stAddr, stRead, stWrite, stDone, stFault} ctrlState_t;

endpackage

// ==== hw/memUnitTop.sv ====
`timescale 1ns/10ps
`include "memUnit_defines.svh"

// memory slice with the sequencer, address generator and data memory
module memUnitTop
	import memUnitPkg::*;
(
	input  logic                clk,
	input  logic                arstN,
	input  logic                issue,
	input  logic [`INST_W-1:0]  inst,
	input  logic [`WORD_W-1:0]  a,
	input  logic [`WORD_W-1:0]  b,
	input  logic [`WORD_W-1:0]  c,
	output logic                idle,
	output logic                done,
	output logic                fault,
	output logic [`WORD_W-1:0]  result
);

	// captured operands going to agen
	memInst_t           instQ;
	logic [`WORD_W-1:0] aQ;
	logic [`WORD_W-1:0] cQ;
	logic [`WORD_W-1:0] ma;
	// data memory port
	logic [`MEM_AW-1:0] memAddr;
	logic               memWe;
	logic               memRe;
	logic [`WORD_W-1:0] memWdata;
	logic [`WORD_W-1:0] memRdata;

	memCtrl ctrl_i (
		.clk      (clk),
		.arstN    (arstN),
		.issue    (issue),
		.inst     (inst),
		.a        (a),
		.b        (b),
		.c        (c),
		.ma       (ma),
		.memRdata (memRdata),
		.instQ    (instQ),
		.aQ       (aQ),
		.cQ       (cQ),
		.memAddr  (memAddr),
		.memWe    (memWe),
		.memRe    (memRe),
		.memWdata (memWdata),
		.idle     (idle),
		.done     (done),
		.fault    (fault),
		.result   (result)
	);

	// address is formed from the registered copies, not the live inputs
	agen agen_i (
		.inst (instQ),
		.a    (aQ),
		.c    (cQ),
		.ma   (ma)
	);

	dataMem mem_i (
		.clk   (clk),
		.arstN (arstN),
		.we    (memWe),
		.re    (memRe),
		.addr  (memAddr),
		.wdata (memWdata),
		.rdata (memRdata)
	);

endmodule

// ==== hw/memUnit_defines.svh ====
`ifndef MEMUNIT_DEFINES_SVH
`define MEMUNIT_DEFINES_SVH

// ==============================
// widths
// ==============================

// operand and address width of the core
`define WORD_W 80
// instruction width
`define INST_W 40
// word address width of the data memory, giving 256 words
`define MEM_AW 8

// ==============================
// opcode classes and opcodes
// ==============================

// the memory opcode is {inst[34:33], inst[9:6]}
// the two high bits choose the class
`define LOAD 6'b00????
`define STORE 6'b01????

// atomic add and indexed load live in the load class
`define AMO 6'h0F
`define MLX 6'h0E
// pushes and indexed store live in the store class
`define PUSH 6'h1D
`define PUSHC 6'h1E
`define MSX 6'h1F

// ==============================
// field positions
// ==============================

// both halves of the memory opcode
`define OPC_HI 34:33
`define OPC_LO 9:6
// decrement amount for a plain push
`define FUNCT5 27:23
// lowest bit of the three bit index scale field at 30:28
`define SCALE_LO 28
// push constant always steps the stack down by this much
`define PUSHC_DEC 10

`endif

// ==== sim.f ====
+incdir+hw
hw/memUnitPkg.sv
hw/agen.sv
hw/dataMem.sv
hw/memCtrl.sv
hw/memUnitTop.sv
bench/memUnitTb.sv
